/* filelist.f */
+incdir+common
+incdir+testbench
common/fpu_op_pkg.sv
common/fpu_num_pkg.sv
common/fpu_unit_if.sv
fpu/fpu_issue.sv
fpu/fpu_cmp.sv
fpu/fpu_f2i.sv
fpu/fpu_i2f.sv
fpu/fpu_top.sv
testbench/tb_fpu.sv

/* Makefile */
# Verilator build and run for the FPU execution block.

TOP ?= tb_fpu
RTL_TOP ?= fpu_top
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass line.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_fpu_vectors.svh */
`ifndef TB_FPU_VECTORS_SVH
`define TB_FPU_VECTORS_SVH

task automatic load_vectors();
	// name, opcode, op1, op2, expected result, expected illegal.
	add_vec("eq_same", FPU_OP_CMP_EQUAL, 32'h3f800000, 32'h3f800000, 32'h00000001, 1'b0);
	add_vec("eq_diff", FPU_OP_CMP_EQUAL, 32'h3f800000, 32'h40000000, 32'h00000000, 1'b0);
	add_vec("eq_zeros", FPU_OP_CMP_EQUAL, 32'h00000000, 32'h80000000, 32'h00000001, 1'b0);
	add_vec("eq_nan", FPU_OP_CMP_EQUAL, 32'h7fc00000, 32'h7fc00000, 32'h00000000, 1'b0);
	add_vec("lt_pos", FPU_OP_CMP_LESS, 32'h3f800000, 32'h40000000, 32'h00000001, 1'b0);
	add_vec("lt_rev", FPU_OP_CMP_LESS, 32'h40000000, 32'h3f800000, 32'h00000000, 1'b0);
	add_vec("lt_neg", FPU_OP_CMP_LESS, 32'hc0000000, 32'hbf800000, 32'h00000001, 1'b0);
	add_vec("lt_zeros", FPU_OP_CMP_LESS, 32'h80000000, 32'h00000000, 32'h00000000, 1'b0);
	add_vec("lt_ninf", FPU_OP_CMP_LESS, 32'hff800000, 32'h3f800000, 32'h00000001, 1'b0);
	add_vec("lt_pinf", FPU_OP_CMP_LESS, 32'h3f800000, 32'h7f800000, 32'h00000001, 1'b0);
	add_vec("lt_nan", FPU_OP_CMP_LESS, 32'h7fc00000, 32'h3f800000, 32'h00000000, 1'b0);
	add_vec("le_same", FPU_OP_CMP_LEQUAL, 32'h3f800000, 32'h3f800000, 32'h00000001, 1'b0);
	add_vec("le_zeros", FPU_OP_CMP_LEQUAL, 32'h00000000, 32'h80000000, 32'h00000001, 1'b0);
	add_vec("le_rev", FPU_OP_CMP_LEQUAL, 32'h40000000, 32'h3f800000, 32'h00000000, 1'b0);
	add_vec("le_nan", FPU_OP_CMP_LEQUAL, 32'h3f800000, 32'h7f800001, 32'h00000000, 1'b0);
	add_vec("min_pos", FPU_OP_MIN, 32'h3f800000, 32'h40000000, 32'h3f800000, 1'b0);
	add_vec("max_pos", FPU_OP_MAX, 32'h3f800000, 32'h40000000, 32'h40000000, 1'b0);
	add_vec("min_zeros", FPU_OP_MIN, 32'h00000000, 32'h80000000, 32'h80000000, 1'b0);
	add_vec("max_zeros", FPU_OP_MAX, 32'h80000000, 32'h00000000, 32'h00000000, 1'b0);
	add_vec("min_nan_a", FPU_OP_MIN, 32'h7fc00000, 32'h40000000, 32'h40000000, 1'b0);
	add_vec("max_nan_b", FPU_OP_MAX, 32'hbf800000, 32'h7f800001, 32'hbf800000, 1'b0);
	add_vec("min_nan_both", FPU_OP_MIN, 32'h7f800001, 32'hffc00000, 32'h7fc00000, 1'b0);
	add_vec("max_ninf", FPU_OP_MAX, 32'hff800000, 32'hbf800000, 32'hbf800000, 1'b0);
	add_vec("sgnj", FPU_OP_SGNJ, 32'h3f800000, 32'hc0000000, 32'hbf800000, 1'b0);
	add_vec("sgnjn", FPU_OP_SGNJN, 32'h3f800000, 32'hc0000000, 32'h3f800000, 1'b0);
	add_vec("sgnjx", FPU_OP_SGNJX, 32'hbf800000, 32'hc0000000, 32'h3f800000, 1'b0);
	add_vec("sgnj_nan", FPU_OP_SGNJ, 32'h7fc00000, 32'hbf800000, 32'hffc00000, 1'b0);
	add_vec("sgnjn_nan", FPU_OP_SGNJN, 32'hffc00001, 32'h40000000, 32'hffc00001, 1'b0);
	add_vec("sgnjx_nan", FPU_OP_SGNJX, 32'h7fc00000, 32'h80000000, 32'hffc00000, 1'b0);
	add_vec("f2i_2p75", FPU_OP_F2I, 32'h40300000, 32'h00000000, 32'h00000002, 1'b0);
	add_vec("f2i_m2p75", FPU_OP_F2I, 32'hc0300000, 32'h00000000, 32'hfffffffe, 1'b0);
	add_vec("f2i_half", FPU_OP_F2I, 32'h3f000000, 32'h00000000, 32'h00000000, 1'b0);
	add_vec("f2i_3e9", FPU_OP_F2I, 32'h4f32d05e, 32'h00000000, 32'h7fffffff, 1'b0);
	add_vec("f2i_m3e9", FPU_OP_F2I, 32'hcf32d05e, 32'h00000000, 32'h80000000, 1'b0);
	add_vec("f2i_nan", FPU_OP_F2I, 32'h7fc00000, 32'h00000000, 32'h7fffffff, 1'b0);
	add_vec("f2i_ninf", FPU_OP_F2I, 32'hff800000, 32'h00000000, 32'h80000000, 1'b0);
	add_vec("f2ui_100p5", FPU_OP_F2UI, 32'h42c90000, 32'h00000000, 32'h00000064, 1'b0);
	add_vec("f2ui_3e9", FPU_OP_F2UI, 32'h4f32d05e, 32'h00000000, 32'hb2d05e00, 1'b0);
	add_vec("f2ui_neg", FPU_OP_F2UI, 32'hc0300000, 32'h00000000, 32'h00000000, 1'b0);
	add_vec("f2ui_nan", FPU_OP_F2UI, 32'h7fc00000, 32'h00000000, 32'hffffffff, 1'b0);
	add_vec("i2f_one", FPU_OP_I2F, 32'h00000001, 32'h00000000, 32'h3f800000, 1'b0);
	add_vec("i2f_mone", FPU_OP_I2F, 32'hffffffff, 32'h00000000, 32'hbf800000, 1'b0);
	add_vec("i2f_seven", FPU_OP_I2F, 32'h00000007, 32'h00000000, 32'h40e00000, 1'b0);
	add_vec("i2f_zero", FPU_OP_I2F, 32'h00000000, 32'h00000000, 32'h00000000, 1'b0);
	add_vec("i2f_max", FPU_OP_I2F, 32'h7fffffff, 32'h00000000, 32'h4f000000, 1'b0);
	add_vec("i2f_min", FPU_OP_I2F, 32'h80000000, 32'h00000000, 32'hcf000000, 1'b0);
	add_vec("i2f_tie_even", FPU_OP_I2F, 32'h7fffff40, 32'h00000000, 32'h4efffffe, 1'b0);
	add_vec("i2f_above", FPU_OP_I2F, 32'h7fffff41, 32'h00000000, 32'h4effffff, 1'b0);
	add_vec("i2f_m2p24", FPU_OP_I2F, 32'hfeffffff, 32'h00000000, 32'hcb800000, 1'b0);
	add_vec("ui2f_max", FPU_OP_UI2F, 32'hffffffff, 32'h00000000, 32'h4f800000, 1'b0);
	add_vec("ui2f_tie_even", FPU_OP_UI2F, 32'h80000080, 32'h00000000, 32'h4f000000, 1'b0);
	add_vec("ui2f_tie_odd", FPU_OP_UI2F, 32'h80000180, 32'h00000000, 32'h4f000002, 1'b0);
	add_vec("ui2f_zero", FPU_OP_UI2F, 32'h00000000, 32'h00000000, 32'h00000000, 1'b0);
	add_vec("add", FPU_OP_ADD, 32'h3f800000, 32'h40000000, 32'h00000000, 1'b1);
	add_vec("sub", FPU_OP_SUB, 32'h3f800000, 32'h40000000, 32'h00000000, 1'b1);
	add_vec("mul", FPU_OP_MUL, 32'h3f800000, 32'h40000000, 32'h00000000, 1'b1);
	add_vec("div", FPU_OP_DIV, 32'h3f800000, 32'h40000000, 32'h00000000, 1'b1);
	add_vec("madd", FPU_OP_MADD, 32'h3f800000, 32'h40000000, 32'h00000000, 1'b1);
endtask

`endif

/* testbench/tb_fpu.sv */
`include "fpu_defines.svh"

`timescale 1ns/1ps

module tb_fpu
	import fpu_op_pkg::*;
();

	localparam int CLK_HALF = 10;
	localparam int RESET_CYCLES = 10;
	localparam int ROUND_TRIPS = 64;
	localparam logic [31:0] LFSR_SEED = 32'd89470;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic clk;
	logic rst_n;
	logic request;
	logic [`FPU_OP_W-1:0] op;
	logic [`FPU_DATA_W-1:0] op1;
	logic [`FPU_DATA_W-1:0] op2;
	logic ready;
	logic illegal;
	logic [`FPU_DATA_W-1:0] result;

	string vec_name[$];
	logic [`FPU_OP_W-1:0] vec_op[$];
	logic [31:0] vec_op1[$];
	logic [31:0] vec_op2[$];
	logic [31:0] vec_exp[$];
	logic vec_ill[$];

	logic [31:0] lfsr;
	int tests = 0;
	int errors = 0;
	int test_errs = 0;
	int cycles = 0;
	int cycle_limit = 0;

	fpu_top u_dut (
		.i_clock(clk),
		.i_rst_n(rst_n),
		.i_request(request),
		.i_op(op),
		.i_op1(op1),
		.i_op2(op2),
		.o_ready(ready),
		.o_illegal(illegal),
		.o_result(result)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers

	`include "tb_fpu_vectors.svh"

	task automatic add_vec(input string name, input logic [`FPU_OP_W-1:0] vop,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp, input logic ill);
		vec_name.push_back(name);
		vec_op.push_back(vop);
		vec_op1.push_back(a);
		vec_op2.push_back(b);
		vec_exp.push_back(exp);
		vec_ill.push_back(ill);
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// one step per bit taken.
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (test_errs == 0) begin
			$display("ok   %s", name);
		end else begin
			errors++;
			$display("bad  %s, %0d mismatches", name, test_errs);
		end
		test_errs = 0;
	endtask

	// lat counts rising edges after the one that samples the request.
	task automatic run_op(input logic [`FPU_OP_W-1:0] vop, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] res, output logic ill, output int lat);
		@(negedge clk);
		request = 1'b1;
		op = vop;
		op1 = a;
		op2 = b;
		lat = -1;
		do begin
			@(negedge clk);
			lat++;
		end while (!ready);
		res = result;
		ill = illegal;
		request = 1'b0;
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
			$display("timeout: the DUT never signalled ready within %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence

	initial begin : main
		logic [31:0] res;
		logic [31:0] flt;
		logic [31:0] mag;
		logic [31:0] sgn;
		logic [31:0] val;
		logic ill;
		int lat;
		string name;

		rst_n = 1'b0;
		request = 1'b0;
		op = '0;
		op1 = '0;
		op2 = '0;
		lfsr = LFSR_SEED;
		load_vectors();
		cycle_limit = vec_name.size() * 40 + ROUND_TRIPS * 80 + RESET_CYCLES;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < vec_name.size(); i++) begin
			run_op(vec_op[i], vec_op1[i], vec_op2[i], res, ill, lat);
			check({vec_name[i], " result"}, vec_exp[i], res);
			check({vec_name[i], " illegal"}, 32'(vec_ill[i]), 32'(ill));
			if (vec_ill[i])
				check({vec_name[i], " latency"}, 32'd1, 32'(lat));
			else if ((vec_op[i] != FPU_OP_I2F) && (vec_op[i] != FPU_OP_UI2F))
				check({vec_name[i], " latency"}, 32'd2, 32'(lat));	// fixed for cmp and f2i.
			finish_test(vec_name[i]);
		end

		// 24-bit values convert exactly both ways.
		for (int k = 0; k < ROUND_TRIPS; k++) begin
			take_bits(24, mag);
			take_bits(1, sgn);
			val = sgn[0] ? -mag : mag;
			name = $sformatf("round_trip_%0d_%08h", k, val);
			run_op(FPU_OP_I2F, val, '0, flt, ill, lat);
			check({name, " i2f illegal"}, 32'd0, 32'(ill));
			run_op(FPU_OP_F2I, flt, '0, res, ill, lat);
			check({name, " value"}, val, res);
			check({name, " latency"}, 32'd2, 32'(lat));
			finish_test(name);
		end

		$display("%0d tests, %0d passed, %0d failed", tests, tests - errors, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* fpu/fpu_top.sv */
`include "fpu_defines.svh"

`timescale 1ns/1ps

module fpu_top
	import fpu_op_pkg::*, fpu_num_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	input logic i_request,
	input logic [`FPU_OP_W-1:0] i_op,
	input word_t i_op1,
	input word_t i_op2,
	output logic o_ready,
	output logic o_illegal,
	output word_t o_result
);

	fpu_unit_if cmp_if();
	fpu_unit_if f2i_if();
	fpu_unit_if i2f_if();

	fpu_issue u_issue (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_op(fpu_op_e'(i_op)),
		.i_op1(i_op1),
		.i_op2(i_op2),
		.o_ready(o_ready),
		.o_illegal(o_illegal),
		.o_result(o_result),
		.cmp_port(cmp_if.issue),
		.f2i_port(f2i_if.issue),
		.i2f_port(i2f_if.issue)
	);

	fpu_cmp u_cmp (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.port(cmp_if.unit)
	);

	fpu_f2i u_f2i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.port(f2i_if.unit)
	);

	fpu_i2f u_i2f (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.port(i2f_if.unit)
	);

endmodule

/* fpu/fpu_i2f.sv */
`include "fpu_defines.svh"

`timescale 1ns/1ps

module fpu_i2f
	import fpu_op_pkg::*, fpu_num_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	fpu_unit_if.unit port
);

	typedef enum logic [1:0] {IDLE, NORM, ROUND} state_e;

	state_e state;
	logic in_neg;
	word_t mag_in;
	logic sign_q;
	word_t mag_q;
	logic [5:0] shift_cnt;
	logic round_up;
	exp_t pk_exp;
	logic [`FPU_DATA_W-2:0] packed_c;

	assign in_neg = (port.op == FPU_OP_I2F) && port.op1[`FPU_DATA_W-1];
	assign mag_in = in_neg ? -port.op1 : port.op1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// round to nearest even and pack

	// guard is bit 7, sticky below it.
	assign round_up = mag_q[7] && (mag_q[8] || (|mag_q[6:0]));
	assign pk_exp = exp_t'(`FPU_EXP_BIAS + `FPU_DATA_W - 1) - exp_t'(shift_cnt);
	assign packed_c = {pk_exp, mag_q[`FPU_DATA_W-2:8]} + (`FPU_DATA_W-1)'(round_up);	// carry bumps exp.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// normalizer FSM

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			shift_cnt <= '0;
			port.done <= 1'b0;
		end else begin
			port.done <= 1'b0;
			case (state)
				IDLE: begin
					if (port.start) begin
						shift_cnt <= '0;
						if (mag_in == '0)
							port.done <= 1'b1;	// zero skips normalizing.
						else
							state <= NORM;
					end
				end
				NORM: begin
					if (mag_q[`FPU_DATA_W-1]) begin
						state <= ROUND;
					end else begin
						shift_cnt <= shift_cnt + 6'd1;
						if (mag_q[`FPU_DATA_W-2])
							state <= ROUND;	// normalized after this shift.
					end
				end
				ROUND: begin
					port.done <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if ((state == IDLE) && port.start) begin
			sign_q <= in_neg;
			mag_q <= mag_in;
			if (mag_in == '0)
				port.result <= '0;
		end else if ((state == NORM) && !mag_q[`FPU_DATA_W-1]) begin
			mag_q <= mag_q << 1;
		end else if (state == ROUND) begin
			port.result <= {sign_q, packed_c};
		end
	end

	a_shift_bound: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(state == NORM) |-> (shift_cnt <= 6'd31));

endmodule

/* fpu/fpu_f2i.sv */
`include "fpu_defines.svh"

`timescale 1ns/1ps

module fpu_f2i
	import fpu_op_pkg::*, fpu_num_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	fpu_unit_if.unit port
);

	fpu_class_e cls;
	logic neg;
	logic is_signed;
	exp_t bexp;
	exp_t uexp;
	word_t sig;
	word_t mag;
	word_t res_c;

	assign cls = fpu_classify(port.op1);
	assign neg = port.op1[`FPU_DATA_W-1];
	assign is_signed = (port.op == FPU_OP_F2I);
	assign bexp = port.op1[`FPU_DATA_W-2:`FPU_MAN_W];
	assign uexp = bexp - exp_t'(`FPU_EXP_BIAS);	// only meaningful when bexp >= bias.
	assign sig = {{(`FPU_DATA_W-`FPU_MAN_W-1){1'b0}}, 1'b1, port.op1[`FPU_MAN_W-1:0]};

	// truncate toward zero.
	always_comb begin
		if (uexp >= exp_t'(`FPU_MAN_W))
			mag = sig << (uexp - exp_t'(`FPU_MAN_W));
		else
			mag = sig >> (exp_t'(`FPU_MAN_W) - uexp);
	end

	always_comb begin
		if (cls == CLS_NAN) begin
			res_c = is_signed ? 32'h7fffffff : 32'hffffffff;
		end else if (bexp < exp_t'(`FPU_EXP_BIAS)) begin
			res_c = '0;	// |x| < 1, zeros and subnormals.
		end else if (is_signed) begin
			if (uexp >= exp_t'(`FPU_DATA_W - 1))
				res_c = neg ? 32'h80000000 : 32'h7fffffff;
			else
				res_c = neg ? -mag : mag;
		end else begin
			if (neg)
				res_c = '0;
			else if (uexp >= exp_t'(`FPU_DATA_W))
				res_c = '1;
			else
				res_c = mag;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			port.done <= 1'b0;
		else
			port.done <= port.start;
	end

	always_ff @(posedge i_clock) begin
		if (port.start)
			port.result <= res_c;
	end

endmodule

/* fpu/fpu_cmp.sv */
`include "fpu_defines.svh"

`timescale 1ns/1ps

module fpu_cmp
	import fpu_op_pkg::*, fpu_num_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	fpu_unit_if.unit port
);

	fpu_class_e cls1;
	fpu_class_e cls2;
	logic s1;
	logic s2;
	logic any_nan;
	logic both_zero;
	logic mag_lt;
	logic mag_gt;
	logic lt_total;
	logic is_equal;
	logic is_less;
	word_t min_w;
	word_t max_w;
	word_t res_c;

	assign cls1 = fpu_classify(port.op1);
	assign cls2 = fpu_classify(port.op2);
	assign s1 = port.op1[`FPU_DATA_W-1];
	assign s2 = port.op2[`FPU_DATA_W-1];
	assign any_nan = (cls1 == CLS_NAN) || (cls2 == CLS_NAN);
	assign both_zero = (cls1 == CLS_ZERO) && (cls2 == CLS_ZERO);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ordering

	assign mag_lt = port.op1[`FPU_DATA_W-2:0] < port.op2[`FPU_DATA_W-2:0];
	assign mag_gt = port.op1[`FPU_DATA_W-2:0] > port.op2[`FPU_DATA_W-2:0];
	assign lt_total = (s1 != s2) ? s1 : (s1 ? mag_gt : mag_lt);	// -0 below +0.

	assign is_equal = !any_nan && ((port.op1 == port.op2) || both_zero);
	assign is_less = !any_nan && !both_zero && lt_total;

	always_comb begin
		if ((cls1 == CLS_NAN) && (cls2 == CLS_NAN)) begin
			min_w = `FPU_CANON_NAN;
			max_w = `FPU_CANON_NAN;
		end else if (cls1 == CLS_NAN) begin
			min_w = port.op2;
			max_w = port.op2;
		end else if (cls2 == CLS_NAN) begin
			min_w = port.op1;
			max_w = port.op1;
		end else begin
			min_w = lt_total ? port.op1 : port.op2;
			max_w = lt_total ? port.op2 : port.op1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result select

	always_comb begin
		case (port.op)
			FPU_OP_CMP_EQUAL: res_c = word_t'(is_equal);
			FPU_OP_CMP_LESS: res_c = word_t'(is_less);
			FPU_OP_CMP_LEQUAL: res_c = word_t'(is_less || is_equal);
			FPU_OP_SGNJ: res_c = {s2, port.op1[`FPU_DATA_W-2:0]};
			FPU_OP_SGNJN: res_c = {~s2, port.op1[`FPU_DATA_W-2:0]};
			FPU_OP_SGNJX: res_c = {s1 ^ s2, port.op1[`FPU_DATA_W-2:0]};
			FPU_OP_MIN: res_c = min_w;
			FPU_OP_MAX: res_c = max_w;
			default: res_c = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			port.done <= 1'b0;
		else
			port.done <= port.start;	// fixed one-cycle latency.
	end

	always_ff @(posedge i_clock) begin
		if (port.start)
			port.result <= res_c;
	end

endmodule

/* fpu/fpu_issue.sv */
`timescale 1ns/1ps

module fpu_issue
	import fpu_op_pkg::*, fpu_num_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	input logic i_request,
	input fpu_op_e i_op,
	input word_t i_op1,
	input word_t i_op2,
	output logic o_ready,
	output logic o_illegal,
	output word_t o_result,
	fpu_unit_if.issue cmp_port,
	fpu_unit_if.issue f2i_port,
	fpu_unit_if.issue i2f_port
);

	typedef enum logic [1:0] {IDLE, WAIT, DONE} state_e;

	state_e state;
	fpu_unit_e dec_unit;
	fpu_unit_e sel_unit;
	logic accept;
	logic unit_done;
	word_t unit_result;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode

	always_comb begin
		case (i_op)
			FPU_OP_F2I, FPU_OP_F2UI: dec_unit = UNIT_F2I;
			FPU_OP_I2F, FPU_OP_UI2F: dec_unit = UNIT_I2F;
			FPU_OP_CMP_EQUAL, FPU_OP_CMP_LESS, FPU_OP_CMP_LEQUAL,
			FPU_OP_SGNJ, FPU_OP_SGNJN, FPU_OP_SGNJX,
			FPU_OP_MIN, FPU_OP_MAX: dec_unit = UNIT_CMP;
			default: dec_unit = UNIT_NONE;	// add/mul/div/fma not built.
		endcase
	end

	assign accept = (state == IDLE) && i_request;

	always_comb begin
		case (sel_unit)
			UNIT_CMP: begin
				unit_done = cmp_port.done;
				unit_result = cmp_port.result;
			end
			UNIT_F2I: begin
				unit_done = f2i_port.done;
				unit_result = f2i_port.result;
			end
			UNIT_I2F: begin
				unit_done = i2f_port.done;
				unit_result = i2f_port.result;
			end
			default: begin
				unit_done = 1'b1;	// illegal op finishes at once.
				unit_result = '0;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			sel_unit <= UNIT_NONE;
			o_ready <= 1'b0;
			o_illegal <= 1'b0;
			o_result <= '0;
			cmp_port.start <= 1'b0;
			f2i_port.start <= 1'b0;
			i2f_port.start <= 1'b0;
		end else begin
			cmp_port.start <= accept && (dec_unit == UNIT_CMP);
			f2i_port.start <= accept && (dec_unit == UNIT_F2I);
			i2f_port.start <= accept && (dec_unit == UNIT_I2F);
			o_ready <= 1'b0;
			o_illegal <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						sel_unit <= dec_unit;
						state <= WAIT;
					end
				end
				WAIT: begin
					if (unit_done) begin
						o_ready <= 1'b1;
						o_illegal <= (sel_unit == UNIT_NONE);
						o_result <= unit_result;
						state <= DONE;
					end
				end
				default: state <= IDLE;	// requester drops i_request here.
			endcase
		end
	end

	// operands held in the unit's interface until done.
	always_ff @(posedge i_clock) begin
		if (accept && (dec_unit == UNIT_CMP)) begin
			cmp_port.op <= i_op;
			cmp_port.op1 <= i_op1;
			cmp_port.op2 <= i_op2;
		end
		if (accept && (dec_unit == UNIT_F2I)) begin
			f2i_port.op <= i_op;
			f2i_port.op1 <= i_op1;
			f2i_port.op2 <= i_op2;
		end
		if (accept && (dec_unit == UNIT_I2F)) begin
			i2f_port.op <= i_op;
			i2f_port.op1 <= i_op1;
			i2f_port.op2 <= i_op2;
		end
	end

	// only the unit that was started may answer.
	a_done_from_sel: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(cmp_port.done || f2i_port.done || i2f_port.done) |-> unit_done);

	a_done_in_wait: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(cmp_port.done || f2i_port.done || i2f_port.done) |-> (state == WAIT));

endmodule

/* common/fpu_unit_if.sv */
`timescale 1ns/1ps

interface fpu_unit_if
	import fpu_op_pkg::*, fpu_num_pkg::*;
();

	logic start;	// one cycle per operation.
	fpu_op_e op;
	word_t op1;
	word_t op2;
	logic done;		// one cycle, result valid.
	word_t result;

	modport issue (
		output start,
		output op,
		output op1,
		output op2,
		input done,
		input result
	);

	modport unit (
		input start,
		input op,
		input op1,
		input op2,
		output done,
		output result
	);

endinterface

/* common/fpu_num_pkg.sv */
`include "fpu_defines.svh"

package fpu_num_pkg;

	typedef logic [`FPU_DATA_W-1:0] word_t;
	typedef logic [`FPU_EXP_W-1:0] exp_t;
	typedef logic [`FPU_MAN_W-1:0] man_t;

	typedef enum logic [2:0] {
		CLS_ZERO,
		CLS_SUBNORMAL,
		CLS_NORMAL,
		CLS_INF,
		CLS_NAN
	} fpu_class_e;

	function automatic fpu_class_e fpu_classify(input word_t w);
		exp_t e;
		man_t m;
		e = w[`FPU_DATA_W-2:`FPU_MAN_W];
		m = w[`FPU_MAN_W-1:0];
		if (e == '1)
			return (m == '0) ? CLS_INF : CLS_NAN;
		if (e == '0)
			return (m == '0) ? CLS_ZERO : CLS_SUBNORMAL;
		return CLS_NORMAL;
	endfunction

endpackage

/* common/fpu_op_pkg.sv */
`include "fpu_defines.svh"

package fpu_op_pkg;

	// encoding follows the core's FPU opcode field.
	typedef enum logic [`FPU_OP_W-1:0] {
		FPU_OP_ADD,
		FPU_OP_SUB,
		FPU_OP_MUL,
		FPU_OP_DIV,
		FPU_OP_MADD,
		FPU_OP_MSUB,
		FPU_OP_NMADD,
		FPU_OP_NMSUB,
		FPU_OP_F2I,
		FPU_OP_F2UI,
		FPU_OP_I2F,
		FPU_OP_UI2F,
		FPU_OP_CMP_EQUAL,
		FPU_OP_CMP_LESS,
		FPU_OP_CMP_LEQUAL,
		FPU_OP_SGNJ,
		FPU_OP_SGNJN,
		FPU_OP_SGNJX,
		FPU_OP_MIN,
		FPU_OP_MAX
	} fpu_op_e;

	// execute unit chosen by decode.
	typedef enum logic [1:0] {
		UNIT_CMP,
		UNIT_F2I,
		UNIT_I2F,
		UNIT_NONE
	} fpu_unit_e;

endpackage

/* common/fpu_defines.svh */
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// single-precision word layout.
`define FPU_DATA_W 32
`define FPU_EXP_W 8
`define FPU_MAN_W 23
`define FPU_EXP_BIAS 127

// opcode field from the core.
`define FPU_OP_W 5

// quiet NaN returned when min/max sees two NaNs.
`define FPU_CANON_NAN 32'h7fc00000

`endif
